// ==== include/mul_settings.svh ====
`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

// Operand and result width
`define MUL_XLEN 64

// Operands widened by two bits so the top Booth group is complete
`define MUL_EXT_W 66

// One partial product per radix-4 digit
`define MUL_PP_NUM 33
`define MUL_PROD_W 132

// Result FIFO depth, also the upstream credits after reset
`define MUL_CREDITS 4

`endif

// ==== hdl/mul_pkg.sv ====
`include "mul_settings.svh"

package mul_pkg;

	// Opcodes of the multiply unit
	typedef enum logic [2:0] {
		MUL_LO  = 3'd0,
		MUL_HSS = 3'd1,
		MUL_HSU = 3'd2,
		MUL_HUU = 3'd3,
		MUL_W   = 3'd4
	} mul_op_e;

	////////////////////////////////////////////////////////////
	// Pipeline payloads
	////////////////////////////////////////////////////////////

	// Request as issued by the core
	typedef struct packed {
		mul_op_e               op;
		logic [`MUL_XLEN-1:0]  a;
		logic [`MUL_XLEN-1:0]  b;
	} mul_req_t;

	// Stage 1, operands already sign or zero extended
	typedef struct packed {
		mul_op_e               op;
		logic [`MUL_EXT_W-1:0] ext_a;
		logic [`MUL_EXT_W-1:0] ext_b;
	} mul_opnd_t;

	// Stage 2, redundant form of the product
	typedef struct packed {
		mul_op_e                op;
		logic [`MUL_PROD_W-1:0] sum;
		logic [`MUL_PROD_W-1:0] carry;
	} mul_csa_t;

	// Final response word
	typedef struct packed {
		logic [`MUL_XLEN-1:0] result;
	} mul_rsp_t;

endpackage

// ==== hdl/mul_operand_prep.sv ====
`include "mul_settings.svh"

module mul_operand_prep (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                req_valid,
	input  mul_pkg::mul_req_t   req,
	output logic                opnd_valid,
	output mul_pkg::mul_opnd_t  opnd
);

	localparam int HALF = `MUL_XLEN / 2;
	localparam int PAD  = `MUL_EXT_W - `MUL_XLEN;

	logic                 a_signed;
	logic                 b_signed;
	logic [`MUL_XLEN-1:0] a_src;
	logic [`MUL_XLEN-1:0] b_src;
	logic [`MUL_EXT_W-1:0] ext_a;
	logic [`MUL_EXT_W-1:0] ext_b;

	// Signedness per operand, rs1 is a and rs2 is b
	always_comb begin
		case (req.op)
			mul_pkg::MUL_HSU: begin
				a_signed = 1'b1;
				b_signed = 1'b0;
			end
			mul_pkg::MUL_HUU: begin
				a_signed = 1'b0;
				b_signed = 1'b0;
			end
			default: begin
				a_signed = 1'b1;
				b_signed = 1'b1;
			end
		endcase
	end

	// Word op only looks at the low halves
	always_comb begin
		a_src = req.a;
		b_src = req.b;
		if (req.op == mul_pkg::MUL_W) begin
			a_src = {{HALF{req.a[HALF-1]}}, req.a[HALF-1:0]};
			b_src = {{HALF{req.b[HALF-1]}}, req.b[HALF-1:0]};
		end
	end

	assign ext_a = {{PAD{a_signed & a_src[`MUL_XLEN-1]}}, a_src};
	assign ext_b = {{PAD{b_signed & b_src[`MUL_XLEN-1]}}, b_src};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			opnd_valid <= 1'b0;
		end else begin
			opnd_valid <= req_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid) begin
			opnd.op    <= req.op;
			opnd.ext_a <= ext_a;
			opnd.ext_b <= ext_b;
		end
	end

endmodule

// ==== hdl/mul_booth_encoder.sv ====
`include "mul_settings.svh"

module mul_booth_encoder (
	input  logic [`MUL_EXT_W-1:0]                   ext_a,
	input  logic [`MUL_EXT_W-1:0]                   ext_b,
	output logic [`MUL_PP_NUM-1:0][`MUL_PROD_W-1:0] pp,
	output logic [`MUL_PP_NUM-1:0]                  neg
);

	localparam int SX_W = `MUL_PROD_W - `MUL_EXT_W;

	// Multiplier with the implicit zero below bit 0
	logic [`MUL_EXT_W:0]    a_pad;
	// Multiplicand times one and times two, full product width
	logic [`MUL_PROD_W-1:0] b_x1;
	logic [`MUL_PROD_W-1:0] b_x2;

	assign a_pad = {ext_a, 1'b0};
	assign b_x1  = {{SX_W{ext_b[`MUL_EXT_W-1]}}, ext_b};
	assign b_x2  = {b_x1[`MUL_PROD_W-2:0], 1'b0};

	////////////////////////////////////////////////////////////
	// Radix-4 digit selection
	////////////////////////////////////////////////////////////

	// Digit groups overlap by one bit: a[2i+1], a[2i], a[2i-1]
	always_comb begin
		logic [2:0]             grp;
		logic [`MUL_PROD_W-1:0] mag;
		logic [`MUL_PROD_W-1:0] row;
		for (int i = 0; i < `MUL_PP_NUM; i++) begin
			grp = a_pad[2*i +: 3];
			case (grp)
				3'b001, 3'b010, 3'b101, 3'b110: begin
					mag = b_x1;
				end
				3'b011, 3'b100: begin
					mag = b_x2;
				end
				default: begin
					mag = '0;
				end
			endcase
			// 111 encodes minus zero, treated as plain zero
			neg[i] = grp[2] & ~(grp[1] & grp[0]);
			// Inverted here, the +1 goes into the tree at bit 2i
			row   = neg[i] ? ~mag : mag;
			pp[i] = row << (2 * i);
		end
	end

endmodule

// ==== hdl/mul_wallace_tree.sv ====
`include "mul_settings.svh"

module mul_wallace_tree (
	input  logic [`MUL_PP_NUM-1:0][`MUL_PROD_W-1:0] pp,
	input  logic [`MUL_PP_NUM-1:0]                  neg,
	output logic [`MUL_PROD_W-1:0]                  sum,
	output logic [`MUL_PROD_W-1:0]                  carry
);

	// Partial products plus one row holding all negate bits
	localparam int ROWS0 = `MUL_PP_NUM + 1;

	// Rows left after a number of 3:2 levels
	function automatic int rows_at(input int lvl);
		int n;
		n = ROWS0;
		for (int l = 0; l < lvl; l++) begin
			n = (n / 3) * 2 + n % 3;
		end
		return n;
	endfunction

	function automatic int level_count();
		int n;
		int cnt;
		n = ROWS0;
		cnt = 0;
		while (n > 2) begin
			n = (n / 3) * 2 + n % 3;
			cnt++;
		end
		return cnt;
	endfunction

	localparam int LEVELS = level_count();

	logic [`MUL_PROD_W-1:0] neg_row;
	logic [`MUL_PROD_W-1:0] row [LEVELS+1][ROWS0];

	// Negate bits never collide, each sits at bit 2i
	always_comb begin
		neg_row = '0;
		for (int i = 0; i < `MUL_PP_NUM; i++) begin
			neg_row[2*i] = neg[i];
		end
	end

	for (genvar i = 0; i < `MUL_PP_NUM; i++) begin : g_init
		assign row[0][i] = pp[i];
	end
	assign row[0][ROWS0-1] = neg_row;

	////////////////////////////////////////////////////////////
	// Carry-save reduction levels
	////////////////////////////////////////////////////////////

	for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_level
		localparam int N_IN  = rows_at(lvl);
		localparam int N_CSA = N_IN / 3;
		localparam int N_OUT = 2 * N_CSA + N_IN % 3;

		for (genvar g = 0; g < N_CSA; g++) begin : g_csa
			logic [`MUL_PROD_W-1:0] in_a;
			logic [`MUL_PROD_W-1:0] in_b;
			logic [`MUL_PROD_W-1:0] in_c;
			logic [`MUL_PROD_W-1:0] maj;
			assign in_a = row[lvl][3*g];
			assign in_b = row[lvl][3*g+1];
			assign in_c = row[lvl][3*g+2];
			assign maj  = (in_a & in_b) | (in_a & in_c) | (in_b & in_c);
			assign row[lvl+1][2*g]   = in_a ^ in_b ^ in_c;
			// Carry out of the top bit falls off, product is mod 2^132
			assign row[lvl+1][2*g+1] = {maj[`MUL_PROD_W-2:0], 1'b0};
		end

		// Rows that do not fill a full compressor move down unchanged
		for (genvar k = 0; k < N_IN % 3; k++) begin : g_pass
			assign row[lvl+1][2*N_CSA+k] = row[lvl][3*N_CSA+k];
		end

		for (genvar r = N_OUT; r < ROWS0; r++) begin : g_zero
			assign row[lvl+1][r] = '0;
		end
	end

	assign sum   = row[LEVELS][0];
	assign carry = row[LEVELS][1];

endmodule

// ==== hdl/mul_array.sv ====
`include "mul_settings.svh"

module mul_array (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               opnd_valid,
	input  mul_pkg::mul_opnd_t opnd,
	output logic               csa_valid,
	output mul_pkg::mul_csa_t  csa
);

	logic [`MUL_PP_NUM-1:0][`MUL_PROD_W-1:0] pp;
	logic [`MUL_PP_NUM-1:0]                  neg;
	logic [`MUL_PROD_W-1:0]                  sum;
	logic [`MUL_PROD_W-1:0]                  carry;

	mul_booth_encoder i_booth (
		.ext_a (opnd.ext_a),
		.ext_b (opnd.ext_b),
		.pp    (pp),
		.neg   (neg)
	);

	mul_wallace_tree i_tree (
		.pp    (pp),
		.neg   (neg),
		.sum   (sum),
		.carry (carry)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			csa_valid <= 1'b0;
		end else begin
			csa_valid <= opnd_valid;
		end
	end

	// Cut between the tree and the final adder
	always_ff @(posedge clk) begin
		if (opnd_valid) begin
			csa.op    <= opnd.op;
			csa.sum   <= sum;
			csa.carry <= carry;
		end
	end

endmodule

// ==== hdl/mul_result_buffer.sv ====
`include "mul_settings.svh"

module mul_result_buffer (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              csa_valid,
	input  mul_pkg::mul_csa_t csa,
	output logic              rsp_valid,
	output mul_pkg::mul_rsp_t rsp,
	input  logic              rsp_credit,
	output logic              req_credit
);

	localparam int DEPTH = `MUL_CREDITS;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int HALF  = `MUL_XLEN / 2;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + PTR_W'(1);
	endfunction

	logic [`MUL_PROD_W-1:0] prod;
	logic [`MUL_XLEN-1:0]   result;
	logic [`MUL_XLEN-1:0]   mem [DEPTH];
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic [CNT_W-1:0]       fill;
	logic [CNT_W-1:0]       dn_credits;
	logic                   pop;

	////////////////////////////////////////////////////////////
	// Final adder and result select
	////////////////////////////////////////////////////////////

	assign prod = csa.sum + csa.carry;

	always_comb begin
		case (csa.op)
			mul_pkg::MUL_HSS, mul_pkg::MUL_HSU, mul_pkg::MUL_HUU: begin
				result = prod[2*`MUL_XLEN-1:`MUL_XLEN];
			end
			mul_pkg::MUL_W: begin
				result = {{HALF{prod[HALF-1]}}, prod[HALF-1:0]};
			end
			default: begin
				result = prod[`MUL_XLEN-1:0];
			end
		endcase
	end

	// Credits bound the occupancy, so a push always finds a slot
	always_ff @(posedge clk) begin
		if (csa_valid) begin
			mem[wr_ptr] <= result;
		end
	end

	assign pop        = (fill != '0) && (dn_credits != '0);
	assign rsp_valid  = pop;
	assign req_credit = pop;
	assign rsp.result = mem[rd_ptr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (csa_valid) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({csa_valid, pop})
				2'b10:   fill <= fill + CNT_W'(1);
				2'b01:   fill <= fill - CNT_W'(1);
				default: fill <= fill;
			endcase
		end
	end

	// Downstream credits, saturating at the buffer depth
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dn_credits <= '0;
		end else begin
			case ({rsp_credit, pop})
				2'b10: begin
					if (dn_credits != CNT_W'(DEPTH)) begin
						dn_credits <= dn_credits + CNT_W'(1);
					end
				end
				2'b01:   dn_credits <= dn_credits - CNT_W'(1);
				default: dn_credits <= dn_credits;
			endcase
		end
	end

endmodule

// ==== hdl/mul_unit_top.sv ====
module mul_unit_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              req_valid,
	input  mul_pkg::mul_req_t req,
	output logic              req_credit,
	output logic              rsp_valid,
	output mul_pkg::mul_rsp_t rsp,
	input  logic              rsp_credit
);

	logic               opnd_valid;
	mul_pkg::mul_opnd_t opnd;
	logic               csa_valid;
	mul_pkg::mul_csa_t  csa;

	// Input side
	mul_operand_prep i_prep (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req        (req),
		.opnd_valid (opnd_valid),
		.opnd       (opnd)
	);

	// Booth recoding and carry-save tree
	mul_array i_array (
		.clk        (clk),
		.rst_n      (rst_n),
		.opnd_valid (opnd_valid),
		.opnd       (opnd),
		.csa_valid  (csa_valid),
		.csa        (csa)
	);

	// Output side with the credit logic
	mul_result_buffer i_buffer (
		.clk        (clk),
		.rst_n      (rst_n),
		.csa_valid  (csa_valid),
		.csa        (csa),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp),
		.rsp_credit (rsp_credit),
		.req_credit (req_credit)
	);

endmodule

// ==== dv/mul_unit_checker.sv ====
`include "mul_settings.svh"

module mul_unit_checker (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input logic req_credit,
	input logic rsp_valid,
	input logic rsp_credit
);

	int dn_held;
	int outstanding;

	// Credits the consumer has granted, saturating at the buffer depth
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dn_held     <= 0;
			outstanding <= 0;
		end else begin
			if (rsp_credit && !rsp_valid && dn_held < `MUL_CREDITS) begin
				dn_held <= dn_held + 1;
			end else if (!rsp_credit && rsp_valid) begin
				dn_held <= dn_held - 1;
			end
			outstanding <= outstanding + int'(req_valid) - int'(req_credit);
		end
	end

	a_rsp_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid |-> dn_held > 0)
		else $error("rsp_valid without a downstream credit");

	a_credit_tracks_rsp: assert property (@(posedge clk) disable iff (!rst_n)
		req_credit == rsp_valid)
		else $error("req_credit does not match rsp_valid");

	a_quiet_in_reset: assert property (@(posedge clk)
		!rst_n |-> (!req_credit && !rsp_valid))
		else $error("outputs active during reset");

	a_outstanding_cap: assert property (@(posedge clk) disable iff (!rst_n)
		outstanding <= `MUL_CREDITS)
		else $error("more requests in flight than upstream credits");

endmodule

bind mul_unit_top mul_unit_checker i_checker (
	.clk        (clk),
	.rst_n      (rst_n),
	.req_valid  (req_valid),
	.req_credit (req_credit),
	.rsp_valid  (rsp_valid),
	.rsp_credit (rsp_credit)
);

// ==== dv/mul_unit_tb.sv ====
`include "mul_settings.svh"

module mul_unit_tb;

	localparam int BURST        = 12;
	localparam int STALL_CYCLES = 40;
	localparam int WAIT_LIMIT   = 2000;

	logic              clk;
	logic              rst_n;
	logic              req_valid;
	mul_pkg::mul_req_t req;
	logic              req_credit;
	logic              rsp_valid;
	mul_pkg::mul_rsp_t rsp;
	logic              rsp_credit;

	// Tests as read from the stim file
	string                names [$];
	mul_pkg::mul_req_t    reqs  [$];
	logic [`MUL_XLEN-1:0] exps  [$];
	// Scoreboard with the oldest request first
	string                sb_name [$];
	logic [`MUL_XLEN-1:0] sb_exp  [$];

	integer seed;
	int     cycle;
	int     up_credits;
	int     next_idx;
	int     issue_limit;
	int     credit_mode;
	int     issued;
	int     received;
	int     returned;
	int     first_rsp;
	int     last_rsp;

	mul_unit_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req        (req),
		.req_credit (req_credit),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp),
		.rsp_credit (rsp_credit)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_equal(input string name, input logic [`MUL_XLEN-1:0] expected,
			input logic [`MUL_XLEN-1:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	task automatic load_stim();
		int                   fd;
		int                   code;
		string                line;
		string                name;
		logic [2:0]           op;
		logic [`MUL_XLEN-1:0] a_v;
		logic [`MUL_XLEN-1:0] b_v;
		logic [`MUL_XLEN-1:0] exp_v;
		mul_pkg::mul_req_t    rq;
		fd = $fopen("dv/mul_stim.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open the stim file dv/mul_stim.txt");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.substr(0, 0) != "#") begin
				code = $sscanf(line, "%s %h %h %h %h", name, op, a_v, b_v, exp_v);
				if (code != 5 || op > 3'd4) begin
					abort_run({"malformed line in the stim file: ", line});
				end
				rq.op = mul_pkg::mul_op_e'(op);
				rq.a  = a_v;
				rq.b  = b_v;
				names.push_back(name);
				reqs.push_back(rq);
				exps.push_back(exp_v);
			end
		end
		$fclose(fd);
		if (reqs.size() < BURST + 2 * `MUL_CREDITS + 2) begin
			abort_run("the stim file holds too few tests");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Per-cycle monitor and driver
	////////////////////////////////////////////////////////////

	// Sample outputs and drive new inputs at the falling edge
	task automatic step();
		integer r;
		@(negedge clk);
		cycle++;
		if (req_credit !== rsp_valid) begin
			abort_run("req_credit and rsp_valid differ in the same cycle");
		end else if (rsp_valid && sb_exp.size() == 0) begin
			abort_run("a response arrived with no request outstanding");
		end else if (rsp_valid) begin
			check_equal(sb_name.pop_front(), sb_exp.pop_front(), rsp.result);
			received++;
			if (first_rsp < 0) begin
				first_rsp = cycle;
			end
			last_rsp = cycle;
		end
		if (req_credit) begin
			up_credits++;
			returned++;
		end
		if (up_credits > `MUL_CREDITS) begin
			abort_run("the unit returned more upstream credits than it granted");
		end
		req_valid = 1'b0;
		if (up_credits > 0 && next_idx < issue_limit) begin
			req       = reqs[next_idx];
			req_valid = 1'b1;
			sb_name.push_back(names[next_idx]);
			sb_exp.push_back(exps[next_idx]);
			next_idx++;
			up_credits--;
			issued++;
		end
		r = $random(seed);
		case (credit_mode)
			1:       rsp_credit = 1'b1;
			2:       rsp_credit = r[0];
			default: rsp_credit = 1'b0;
		endcase
	endtask

	task automatic run_cycles(input int n);
		repeat (n) begin
			step();
		end
	endtask

	// Until everything up to issue_limit is sent and answered
	task automatic wait_drain(input string what);
		int n;
		n = 0;
		while ((next_idx < issue_limit || sb_exp.size() != 0) && n < WAIT_LIMIT) begin
			step();
			n++;
		end
		if (next_idx < issue_limit || sb_exp.size() != 0) begin
			abort_run($sformatf("timed out waiting for %s", what));
		end
	endtask

	initial begin
		seed        = 32'h63af_037f;
		rst_n       = 1'b0;
		req_valid   = 1'b0;
		req         = '0;
		rsp_credit  = 1'b0;
		cycle       = 0;
		up_credits  = `MUL_CREDITS;
		next_idx    = 0;
		issue_limit = 0;
		credit_mode = 0;
		issued      = 0;
		received    = 0;
		returned    = 0;
		first_rsp   = -1;
		last_rsp    = -1;
		load_stim();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Directed tests back to back with a downstream credit every cycle
		credit_mode = 1;
		issue_limit = BURST;
		wait_drain("the directed burst");
		check_equal("burst spacing", BURST - 1, last_rsp - first_rsp);

		// Spend the full downstream credit count the unit now holds
		run_cycles(`MUL_CREDITS + 1);
		credit_mode = 0;
		issue_limit = next_idx + `MUL_CREDITS;
		wait_drain("responses on held credits");

		////////////////////////////////////////////////////////////
		// Starved downstream
		////////////////////////////////////////////////////////////

		issued      = 0;
		received    = 0;
		returned    = 0;
		issue_limit = next_idx + `MUL_CREDITS + 2;
		run_cycles(STALL_CYCLES);
		check_equal("requests before stall", `MUL_CREDITS, issued);
		check_equal("responses while starved", 0, received);
		check_equal("credits while starved", 0, returned);

		// Held results drain first once credits come back at random
		credit_mode = 2;
		issue_limit = reqs.size();
		wait_drain("the rest of the stim file");

		// Whole file once more under random credit timing
		next_idx = 0;
		wait_drain("the random credit pass");

		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== dv/mul_stim.txt ====
# name  op  a  b  expected, all but the name in hex
# op: 0 MUL_LO, 1 MUL_HSS, 2 MUL_HSU, 3 MUL_HUU, 4 MUL_W
lo_small      0 0000000000000003 0000000000000005 000000000000000f
lo_zero       0 0000000000000000 ffffffffffffffff 0000000000000000
lo_all_ones   0 ffffffffffffffff ffffffffffffffff 0000000000000001
lo_neg_pos    0 ffffffffffffffff 0000000000000007 fffffffffffffff9
lo_neg_two    0 fffffffffffffffe 0000000000001234 ffffffffffffdb98
hss_min_m1    1 8000000000000000 ffffffffffffffff 0000000000000000
hsu_min_m1    2 8000000000000000 ffffffffffffffff 8000000000000000
huu_min_m1    3 8000000000000000 ffffffffffffffff 7fffffffffffffff
w_upper_junk  4 ffffffff00000003 1234567800000005 000000000000000f
w_neg_word    4 00000000ffffffff 0000000000000002 fffffffffffffffe
w_bit31       4 0000000040000000 0000000000000002 ffffffff80000000
w_wrap        4 aaaaaaaa00010000 5555555500010000 0000000000000000
hss_m1_m1     1 ffffffffffffffff ffffffffffffffff 0000000000000000
hsu_m1_m1     2 ffffffffffffffff ffffffffffffffff ffffffffffffffff
huu_m1_m1     3 ffffffffffffffff ffffffffffffffff fffffffffffffffe
hss_m1_two    1 ffffffffffffffff 0000000000000002 ffffffffffffffff
huu_m1_two    3 ffffffffffffffff 0000000000000002 0000000000000001
hsu_two_m1    2 0000000000000002 ffffffffffffffff 0000000000000001
hss_two_m1    1 0000000000000002 ffffffffffffffff ffffffffffffffff
hss_pos       1 4000000000000000 0000000000000008 0000000000000002
lo_shift32    0 0000000100000000 0000000000000003 0000000300000000
lo_word_sq    0 00000000ffffffff 00000000ffffffff fffffffe00000001
lo_wrap       0 0000000000000010 0fffffffffffffff fffffffffffffff0
lo_passthru   0 123456789abcdef0 0000000000000001 123456789abcdef0
lo_top_bit    0 8000000000000000 0000000000000002 0000000000000000
w_all_ones    4 0000000000010001 000000000000ffff ffffffffffffffff
huu_2p64      3 0000000100000000 0000000100000000 0000000000000001

// ==== tb.f ====
+incdir+include
hdl/mul_pkg.sv
hdl/mul_operand_prep.sv
hdl/mul_booth_encoder.sv
hdl/mul_wallace_tree.sv
hdl/mul_array.sv
hdl/mul_result_buffer.sv
hdl/mul_unit_top.sv
dv/mul_unit_checker.sv
dv/mul_unit_tb.sv

// ==== Bender.yml ====
package:
  name: mul_unit

export_include_dirs:
  - include

sources:
  - hdl/mul_pkg.sv
  - hdl/mul_operand_prep.sv
  - hdl/mul_booth_encoder.sv
  - hdl/mul_wallace_tree.sv
  - hdl/mul_array.sv
  - hdl/mul_result_buffer.sv
  - hdl/mul_unit_top.sv
  - target: test
    files:
      - dv/mul_unit_checker.sv
      - dv/mul_unit_tb.sv
